/* build.f */
+incdir+hdl
hdl/dmaRingPkg.sv
hdl/axiReadMaster.sv
hdl/axiWriteMaster.sv
hdl/ringFetcher.sv
hdl/blockBuffer.sv
hdl/ringDrainer.sv
hdl/dmaRingTop.sv
tb/hostMemModel.sv
tb/dmaRingTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module dmaRingTb -f build.f -o dmaRingSim
./obj_dir/dmaRingSim > sim.log 2>&1 || true
cat sim.log
if grep -q "All tests passed!" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

/* tb/dmaRingTb.sv */
`include "dmaRing_cfg.svh"

module dmaRingTb
   import dmaRingPkg::*;
();

   typedef struct packed {
      logic [`ADDR_W-1:0]   addr;
      logic [`DATA_W-1:0]   data;
      logic [`DATA_W/8-1:0] strb;
   } wrRec_t;

   // Reset, idle test, then 25 blocks at up to four poll periods each, plus margin
   localparam int TIMEOUT_CYCLES = 4 + 3 * `POLL_INTERVAL + 25 * 4 * `POLL_INTERVAL + 700;

   logic               clk = 1'b0;
   logic               rst_n;
   axiAr_t             ar;
   logic               arready;
   axiR_t              r;
   logic               rready;
   axiAw_t             aw;
   logic               awready;
   axiW_t              w;
   logic               wready;
   axiB_t              b;
   logic               bready;
   logic               jitter;
   logic [7:0]         rnd;
   logic               wrSeen;
   logic [`ADDR_W-1:0] wrSeenAddr;
   logic [`DATA_W-1:0] wrSeenData;
   logic [`DATA_W/8-1:0] wrSeenStrb;
   logic [31:0]        lfsr;
   logic [`DATA_W-1:0] inData [`RING_SLOTS][`BLOCK_BEATS];
   wrRec_t             expQ [$];
   int                 errors = 0;
   int                 writesSeen = 0;
   int                 cycles = 0;
   int                 testsRun = 0;
   int                 testsFailed = 0;

   dmaRingTop dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .ar      (ar),
      .arready (arready),
      .r       (r),
      .rready  (rready),
      .aw      (aw),
      .awready (awready),
      .w       (w),
      .wready  (wready),
      .b       (b),
      .bready  (bready)
   );

   hostMemModel host (
      .clk        (clk),
      .rst_n      (rst_n),
      .ar         (ar),
      .arready    (arready),
      .r          (r),
      .rready     (rready),
      .aw         (aw),
      .awready    (awready),
      .w          (w),
      .wready     (wready),
      .b          (b),
      .bready     (bready),
      .jitter     (jitter),
      .rnd        (rnd),
      .wrSeen     (wrSeen),
      .wrSeenAddr (wrSeenAddr),
      .wrSeenData (wrSeenData),
      .wrSeenStrb (wrSeenStrb)
   );

   always #5 clk = ~clk;

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrNext(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [`DATA_W-1:0] takeBits(int n);
      logic [`DATA_W-1:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsrNext(lfsr);
         v    = {v[`DATA_W-2:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [`DATA_W-1:0] ptrWordFor(int slot);
      return `DATA_W'(slot % `RING_SLOTS) << 12;
   endfunction

   // Expected outbound traffic of one block: beats copied, then the pointer
   function automatic void expectBlock(int slot);
      wrRec_t rec;
      rec.strb = '1;
      for (int beat = 0; beat < `BLOCK_BEATS; beat++) begin
         rec.addr = `OB_RING_BASE + `ADDR_W'(slot) * `SLOT_STRIDE
                    + `ADDR_W'(beat) * `BEAT_STRIDE;
         rec.data = inData[slot][beat];
         expQ.push_back(rec);
      end
      rec.addr = `PTR_OUT_ADDR;
      rec.data = ptrWordFor(slot + 1);
      expQ.push_back(rec);
   endfunction

   task automatic loadRing();
      for (int slot = 0; slot < `RING_SLOTS; slot++) begin
         for (int beat = 0; beat < `BLOCK_BEATS; beat++) begin
            host.writeWord(`IB_RING_BASE + `ADDR_W'(slot) * `SLOT_STRIDE
                           + `ADDR_W'(beat) * `BEAT_STRIDE, inData[slot][beat]);
         end
      end
   endtask

   task automatic waitDrained();
      while (expQ.size() != 0) begin
         @(posedge clk);
      end
      @(negedge clk);
   endtask

   // Fetcher sits at slot 1, so pointer 0 brings slots 1 to 7 and pointer 1 brings slot 0
   task automatic copyFullRing();
      for (int slot = 1; slot < `RING_SLOTS; slot++) begin
         expectBlock(slot);
      end
      host.writeWord(`PTR_IN_ADDR, ptrWordFor(0));
      waitDrained();
      expectBlock(0);
      host.writeWord(`PTR_IN_ADDR, ptrWordFor(1));
      waitDrained();
   endtask

   task automatic checkOutSlot(int slot);
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] got;
      for (int beat = 0; beat < `BLOCK_BEATS; beat++) begin
         addr = `OB_RING_BASE + `ADDR_W'(slot) * `SLOT_STRIDE + `ADDR_W'(beat) * `BEAT_STRIDE;
         got  = host.readWord(addr);
         if (got !== inData[slot][beat]) begin
            errors++;
            $display("[FAIL] %0t: outbound slot %0d beat %0d holds %h, expected %h",
                     $time, slot, beat, got, inData[slot][beat]);
         end
      end
   endtask

   task automatic checkOutPtr(int slot);
      logic [`DATA_W-1:0] got;
      got = host.readWord(`PTR_OUT_ADDR);
      if (got !== ptrWordFor(slot)) begin
         errors++;
         $display("[FAIL] %0t: outbound pointer %h, expected %h", $time, got, ptrWordFor(slot));
      end
   endtask

   task automatic checkWholeRing();
      for (int slot = 0; slot < `RING_SLOTS; slot++) begin
         checkOutSlot(slot);
      end
      checkOutPtr(1);
   endtask

   task automatic reportTest(string name, int errBefore);
      testsRun++;
      if (errors == errBefore) begin
         $display("test %s: passed", name);
      end else begin
         testsFailed++;
         $display("test %s: failed with %0d errors", name, errors - errBefore);
      end
   endtask

   always @(negedge clk) begin
      rnd = 8'(takeBits(8));
   end

   // Every accepted write is matched in order against the reference
   always @(negedge clk) begin
      wrRec_t got;
      wrRec_t want;
      got = '{addr: wrSeenAddr, data: wrSeenData, strb: wrSeenStrb};
      if (wrSeen) begin
         writesSeen++;
         if (expQ.size() == 0) begin
            errors++;
            $display("[FAIL] %0t: unexpected write of %h to %h", $time, got.data, got.addr);
         end else begin
            want = expQ.pop_front();
            if (got !== want) begin
               errors++;
               $display("[FAIL] %0t: write %h <= %h strobes %h, expected %h <= %h strobes %h",
                        $time, got.addr, got.data, got.strb,
                        want.addr, want.data, want.strb);
            end
         end
      end
   end

   initial begin
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Run timed out after %0d cycles, the DUT did not finish", cycles);
      $display("Test failures found");
      $finish;
   end

   initial begin
      int errBefore;
      rst_n  = 1'b0;
      jitter = 1'b0;
      rnd    = '0;
      lfsr   = 32'h752bc233;
      for (int slot = 0; slot < `RING_SLOTS; slot++) begin
         for (int beat = 0; beat < `BLOCK_BEATS; beat++) begin
            inData[slot][beat] = takeBits(`DATA_W);
         end
      end
      @(negedge clk);
      loadRing();
      host.writeWord(`PTR_IN_ADDR, ptrWordFor(0));
      repeat (3) @(negedge clk);
      rst_n = 1'b1;

      errBefore = errors;
      @(negedge clk);
      if (ar.arvalid || rready || aw.awvalid || w.wvalid || bready) begin
         errors++;
         $display("[FAIL] %0t: bus outputs not idle after reset", $time);
      end
      repeat (3 * `POLL_INTERVAL) @(negedge clk);
      if (writesSeen != 0) begin
         errors++;
         $display("[FAIL] %0t: %0d writes while the host pointer stood still", $time, writesSeen);
      end
      reportTest("reset and idle", errBefore);

      errBefore = errors;
      expectBlock(0);
      host.writeWord(`PTR_IN_ADDR, ptrWordFor(1));
      waitDrained();
      checkOutSlot(0);
      checkOutPtr(1);
      reportTest("single block", errBefore);

      errBefore = errors;
      loadRing();
      copyFullRing();
      checkWholeRing();
      reportTest("several blocks and wrap", errBefore);

      errBefore = errors;
      jitter = 1'b1;
      loadRing();
      copyFullRing();
      checkWholeRing();
      reportTest("back-pressure", errBefore);

      errBefore = errors;
      loadRing();
      host.armReadErr(`IB_RING_BASE + 3 * `SLOT_STRIDE + 2 * `BEAT_STRIDE);
      host.armWriteErr(`OB_RING_BASE + 5 * `SLOT_STRIDE + 1 * `BEAT_STRIDE);
      copyFullRing();
      checkWholeRing();
      if (host.errorsPending()) begin
         errors++;
         $display("An injected error response was never delivered to the DUT");
      end
      reportTest("error retry", errBefore);

      $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
               testsRun, testsRun - testsFailed, testsFailed, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* tb/hostMemModel.sv */
`include "dmaRing_cfg.svh"

module hostMemModel
   import dmaRingPkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  axiAr_t             ar,
   output logic               arready,
   output axiR_t              r,
   input  logic               rready,
   input  axiAw_t             aw,
   output logic               awready,
   input  axiW_t              w,
   output logic               wready,
   output axiB_t              b,
   input  logic               bready,
   input  logic               jitter,
   input  logic [7:0]         rnd,
   output logic               wrSeen,
   output logic [`ADDR_W-1:0] wrSeenAddr,
   output logic [`DATA_W-1:0] wrSeenData,
   output logic [`DATA_W/8-1:0] wrSeenStrb
);

   logic [`DATA_W-1:0] store [logic [`ADDR_W-1:0]];
   logic [`ADDR_W-1:0] rdAddr;
   logic [`ADDR_W-1:0] wrAddr;
   logic [`DATA_W-1:0] wrData;
   logic [`DATA_W/8-1:0] wrStrb;
   logic [`ADDR_W-1:0] rdErrAddr;
   logic [`ADDR_W-1:0] wrErrAddr;
   logic               rdErrArmed = 1'b0;
   logic               wrErrArmed = 1'b0;
   logic               rdPend;
   logic               awDone;
   logic               wDone;
   logic [1:0]         arDly;
   logic [1:0]         rDly;
   logic [1:0]         awDly;
   logic [1:0]         wDly;
   logic [1:0]         bDly;

   function automatic logic [1:0] pickDelay(logic [1:0] bits);
      return jitter ? bits : 2'd0;
   endfunction

   // Unwritten words read back as a pattern of their own address
   function automatic logic [`DATA_W-1:0] readWord(logic [`ADDR_W-1:0] addr);
      return store.exists(addr) ? store[addr] : {addr, ~addr};
   endfunction

   task automatic writeWord(logic [`ADDR_W-1:0] addr, logic [`DATA_W-1:0] data);
      store[addr] = data;
   endtask

   task automatic armReadErr(logic [`ADDR_W-1:0] addr);
      rdErrAddr  = addr;
      rdErrArmed = 1'b1;
   endtask

   task automatic armWriteErr(logic [`ADDR_W-1:0] addr);
      wrErrAddr  = addr;
      wrErrArmed = 1'b1;
   endtask

   function automatic logic errorsPending();
      return rdErrArmed || wrErrArmed;
   endfunction

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arready <= 1'b0;
         awready <= 1'b0;
         wready  <= 1'b0;
         r       <= '0;
         b       <= '0;
         wrSeen  <= 1'b0;
         rdPend  <= 1'b0;
         awDone  <= 1'b0;
         wDone   <= 1'b0;
         arDly   <= 2'd0;
         rDly    <= 2'd0;
         awDly   <= 2'd0;
         wDly    <= 2'd0;
         bDly    <= 2'd0;
      end else begin
         wrSeen <= 1'b0;
         if (ar.arvalid && arready) begin
            arready <= 1'b0;
            rdAddr  <= ar.araddr;
            rdPend  <= 1'b1;
            arDly   <= pickDelay(rnd[1:0]);
            rDly    <= pickDelay(rnd[3:2]);
         end else if (ar.arvalid && !rdPend) begin
            if (arDly == 2'd0) begin
               arready <= 1'b1;
            end else begin
               arDly <= arDly - 2'd1;
            end
         end
         if (r.rvalid && rready) begin
            r.rvalid <= 1'b0;
            rdPend   <= 1'b0;
         end else if (rdPend && !r.rvalid) begin
            if (rDly == 2'd0) begin
               r.rvalid <= 1'b1;
               r.rdata  <= readWord(rdAddr);
               r.rresp  <= 2'b00;
               // One-shot SLVERR
               if (rdErrArmed && rdAddr == rdErrAddr) begin
                  r.rresp    <= 2'b10;
                  rdErrArmed = 1'b0;
               end
            end else begin
               rDly <= rDly - 2'd1;
            end
         end
         if (aw.awvalid && awready) begin
            awready <= 1'b0;
            awDone  <= 1'b1;
            wrAddr  <= aw.awaddr;
            awDly   <= pickDelay(rnd[5:4]);
         end else if (aw.awvalid && !awDone) begin
            if (awDly == 2'd0) begin
               awready <= 1'b1;
            end else begin
               awDly <= awDly - 2'd1;
            end
         end
         if (w.wvalid && wready) begin
            wready <= 1'b0;
            wDone  <= 1'b1;
            wrData <= w.wdata;
            wrStrb <= w.wstrb;
            wDly   <= pickDelay(rnd[7:6]);
         end else if (w.wvalid && !wDone) begin
            if (wDly == 2'd0) begin
               wready <= 1'b1;
            end else begin
               wDly <= wDly - 2'd1;
            end
         end
         if (b.bvalid && bready) begin
            b.bvalid <= 1'b0;
            awDone   <= 1'b0;
            wDone    <= 1'b0;
            bDly     <= pickDelay(rnd[1:0]);
         end else if (awDone && wDone && !b.bvalid) begin
            if (bDly == 2'd0) begin
               b.bvalid <= 1'b1;
               if (wrErrArmed && wrAddr == wrErrAddr) begin
                  b.bresp    <= 2'b10;
                  wrErrArmed = 1'b0;
               end else begin
                  // Only accepted writes land in memory and in the log
                  b.bresp        <= 2'b00;
                  store[wrAddr]  = wrData;
                  wrSeen         <= 1'b1;
                  wrSeenAddr     <= wrAddr;
                  wrSeenData     <= wrData;
                  wrSeenStrb     <= wrStrb;
               end
            end else begin
               bDly <= bDly - 2'd1;
            end
         end
      end
   end

endmodule

/* hdl/dmaRingTop.sv */
module dmaRingTop
   import dmaRingPkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   output axiAr_t ar,
   input  logic   arready,
   input  axiR_t  r,
   output logic   rready,
   output axiAw_t aw,
   input  logic   awready,
   output axiW_t  w,
   input  logic   wready,
   input  axiB_t  b,
   output logic   bready
);

   rdReq_t    rdReq;
   rdRsp_t    rdRsp;
   wrReq_t    wrReq;
   wrRsp_t    wrRsp;
   logic      bufWrEn;
   beatIdx_t  bufWrBeat;
   beatWord_t bufWrData;
   logic      fillDone;
   slotIdx_t  fillSlot;
   logic      bankFree;
   logic      rdEn;
   beatIdx_t  rdBeat;
   beatWord_t rdData;
   logic      bankReady;
   slotIdx_t  readySlot;
   logic      drainDone;

   axiReadMaster uRead (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (rdReq),
      .rsp     (rdRsp),
      .ar      (ar),
      .arready (arready),
      .r       (r),
      .rready  (rready)
   );

   axiWriteMaster uWrite (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (wrReq),
      .rsp     (wrRsp),
      .aw      (aw),
      .awready (awready),
      .w       (w),
      .wready  (wready),
      .b       (b),
      .bready  (bready)
   );

   // Producer side
   ringFetcher uFetch (
      .clk       (clk),
      .rst_n     (rst_n),
      .rdReq     (rdReq),
      .rdRsp     (rdRsp),
      .bankFree  (bankFree),
      .bufWrEn   (bufWrEn),
      .bufWrBeat (bufWrBeat),
      .bufWrData (bufWrData),
      .fillDone  (fillDone),
      .fillSlot  (fillSlot)
   );

   blockBuffer uBuf (
      .clk       (clk),
      .rst_n     (rst_n),
      .wrEn      (bufWrEn),
      .wrBeat    (bufWrBeat),
      .wrData    (bufWrData),
      .fillDone  (fillDone),
      .fillSlot  (fillSlot),
      .bankFree  (bankFree),
      .rdEn      (rdEn),
      .rdBeat    (rdBeat),
      .rdData    (rdData),
      .bankReady (bankReady),
      .readySlot (readySlot),
      .drainDone (drainDone)
   );

   // Consumer side
   ringDrainer uDrain (
      .clk       (clk),
      .rst_n     (rst_n),
      .bankReady (bankReady),
      .readySlot (readySlot),
      .rdEn      (rdEn),
      .rdBeat    (rdBeat),
      .rdData    (rdData),
      .drainDone (drainDone),
      .wrReq     (wrReq),
      .wrRsp     (wrRsp)
   );

endmodule

/* hdl/ringDrainer.sv */
`include "dmaRing_cfg.svh"

module ringDrainer
   import dmaRingPkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      bankReady,
   input  slotIdx_t  readySlot,
   output logic      rdEn,
   output beatIdx_t  rdBeat,
   input  beatWord_t rdData,
   output logic      drainDone,
   output wrReq_t    wrReq,
   input  wrRsp_t    wrRsp
);

   typedef enum logic [2:0] {
      stIdle,
      stRead,
      stWrite,
      stPtr,
      stDone
   } drainState_t;

   drainState_t        state;
   beatIdx_t           beat;
   logic               rspOk;
   slotIdx_t           nextSlot;
   beatWord_t          ptrBeat;
   logic [`ADDR_W-1:0] beatAddr;

   assign rspOk    = wrRsp.done && !wrRsp.err;
   assign nextSlot = (readySlot == slotIdx_t'(`RING_SLOTS - 1)) ? '0 : readySlot + 1'b1;
   assign beatAddr = `OB_RING_BASE + `ADDR_W'(readySlot) * `SLOT_STRIDE
                     + `ADDR_W'(beat) * `BEAT_STRIDE;

   always_comb begin
      ptrBeat          = '0;
      ptrBeat.ptr.slot = 4'(nextSlot);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= stIdle;
         beat  <= '0;
      end else begin
         case (state)
            stIdle: begin
               if (bankReady) begin
                  beat  <= '0;
                  state <= stRead;
               end
            end
            // Buffer data shows up the cycle after the strobe
            stRead: state <= stWrite;
            stWrite: begin
               if (rspOk) begin
                  beat  <= beat + 1'b1;
                  state <= (beat == beatIdx_t'(`BLOCK_BEATS - 1)) ? stPtr : stRead;
               end
            end
            stPtr: begin
               if (rspOk) begin
                  state <= stDone;
               end
            end
            stDone: state <= stIdle;
            default: state <= stIdle;
         endcase
      end
   end

   // rdData holds until the next strobe, so the payload stays put on retry
   assign wrReq = '{valid: (state == stWrite) || (state == stPtr),
                    addr:  (state == stPtr) ? `PTR_OUT_ADDR : beatAddr,
                    data:  (state == stPtr) ? ptrBeat : rdData};

   assign rdEn      = (state == stRead);
   assign rdBeat    = beat;
   assign drainDone = (state == stDone);

endmodule

/* hdl/blockBuffer.sv */
`include "dmaRing_cfg.svh"

module blockBuffer
   import dmaRingPkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      wrEn,
   input  beatIdx_t  wrBeat,
   input  beatWord_t wrData,
   input  logic      fillDone,
   input  slotIdx_t  fillSlot,
   output logic      bankFree,
   input  logic      rdEn,
   input  beatIdx_t  rdBeat,
   output beatWord_t rdData,
   output logic      bankReady,
   output slotIdx_t  readySlot,
   input  logic      drainDone
);

   beatWord_t  mem [2][`BLOCK_BEATS];
   slotIdx_t   tag [2];
   logic [1:0] full;
   logic       fillBank;
   logic       drainBank;

   // Banks are taken in turn on both sides, so block order holds
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full      <= 2'b00;
         fillBank  <= 1'b0;
         drainBank <= 1'b0;
      end else begin
         if (fillDone) begin
            full[fillBank] <= 1'b1;
            fillBank       <= ~fillBank;
         end
         if (drainDone) begin
            full[drainBank] <= 1'b0;
            drainBank       <= ~drainBank;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[fillBank][wrBeat] <= wrData;
      end
      if (fillDone) begin
         tag[fillBank] <= fillSlot;
      end
      if (rdEn) begin
         rdData <= mem[drainBank][rdBeat];
      end
   end

   assign bankFree  = !full[fillBank];
   assign bankReady = full[drainBank];
   assign readySlot = tag[drainBank];

endmodule

/* hdl/ringFetcher.sv */
`include "dmaRing_cfg.svh"

module ringFetcher
   import dmaRingPkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   output rdReq_t    rdReq,
   input  rdRsp_t    rdRsp,
   input  logic      bankFree,
   output logic      bufWrEn,
   output beatIdx_t  bufWrBeat,
   output beatWord_t bufWrData,
   output logic      fillDone,
   output slotIdx_t  fillSlot
);

   typedef enum logic [1:0] {
      stIdle,
      stPoll,
      stFetch,
      stDone
   } fetchState_t;

   fetchState_t                       state;
   logic [$clog2(`POLL_INTERVAL)-1:0] pollCnt;
   logic                              pollExpired;
   slotIdx_t                          fetchSlot;
   beatIdx_t                          beat;
   logic                              rspOk;
   logic [`ADDR_W-1:0]                beatAddr;

   assign pollExpired = (pollCnt == ($clog2(`POLL_INTERVAL))'(`POLL_INTERVAL - 1));
   assign rspOk       = rdRsp.done && !rdRsp.err;
   assign beatAddr    = `IB_RING_BASE + `ADDR_W'(fetchSlot) * `SLOT_STRIDE
                        + `ADDR_W'(beat) * `BEAT_STRIDE;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= stIdle;
         pollCnt   <= '0;
         fetchSlot <= '0;
         beat      <= '0;
      end else begin
         pollCnt <= pollExpired ? '0 : pollCnt + 1'b1;
         case (state)
            stIdle: begin
               if (pollExpired && bankFree) begin
                  state <= stPoll;
               end
            end
            stPoll: begin
               // Same slot as ours means the host has nothing new
               if (rspOk) begin
                  beat  <= '0;
                  state <= (rdRsp.data.ptr.slot != 4'(fetchSlot)) ? stFetch : stIdle;
               end
            end
            stFetch: begin
               if (rspOk) begin
                  beat <= beat + 1'b1;
                  if (beat == beatIdx_t'(`BLOCK_BEATS - 1)) begin
                     state <= stDone;
                  end
               end
            end
            stDone: begin
               fetchSlot <= (fetchSlot == slotIdx_t'(`RING_SLOTS - 1)) ? '0 : fetchSlot + 1'b1;
               state     <= stIdle;
            end
            default: state <= stIdle;
         endcase
      end
   end

   // Error response leaves valid and address as they are, so the read repeats
   assign rdReq = '{valid: (state == stPoll) || (state == stFetch),
                    addr:  (state == stPoll) ? `PTR_IN_ADDR : beatAddr};

   assign bufWrEn   = (state == stFetch) && rspOk;
   assign bufWrBeat = beat;
   assign bufWrData = rdRsp.data;
   assign fillDone  = (state == stDone);
   assign fillSlot  = fetchSlot;

endmodule

/* hdl/axiWriteMaster.sv */
`include "dmaRing_cfg.svh"

module axiWriteMaster
   import dmaRingPkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  wrReq_t req,
   output wrRsp_t rsp,
   output axiAw_t aw,
   input  logic   awready,
   output axiW_t  w,
   input  logic   wready,
   input  axiB_t  b,
   output logic   bready
);

   typedef enum logic [1:0] {
      stIdle,
      stSend,
      stResp
   } wrState_t;

   wrState_t           state;
   logic               awValid;
   logic               wValid;
   logic [`ADDR_W-1:0] awAddr;
   logic [`DATA_W-1:0] wData;
   logic               rspDone;
   logic               rspErr;
   logic               take;
   logic               awSent;
   logic               wSent;

   assign take = (state == stIdle) && req.valid && !rspDone;

   // Channel counts as sent once its valid is low or being accepted now
   assign awSent = !awValid || awready;
   assign wSent  = !wValid || wready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= stIdle;
         awValid <= 1'b0;
         wValid  <= 1'b0;
         bready  <= 1'b0;
         rspDone <= 1'b0;
         rspErr  <= 1'b0;
      end else begin
         rspDone <= 1'b0;
         case (state)
            stIdle: begin
               if (take) begin
                  awValid <= 1'b1;
                  wValid  <= 1'b1;
                  state   <= stSend;
               end
            end
            stSend: begin
               if (awValid && awready) begin
                  awValid <= 1'b0;
               end
               if (wValid && wready) begin
                  wValid <= 1'b0;
               end
               if (awSent && wSent) begin
                  bready <= 1'b1;
                  state  <= stResp;
               end
            end
            stResp: begin
               if (b.bvalid) begin
                  bready  <= 1'b0;
                  rspDone <= 1'b1;
                  rspErr  <= (b.bresp != 2'b00);
                  state   <= stIdle;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         awAddr <= req.addr;
         wData  <= req.data;
      end
   end

   assign aw  = '{awaddr: awAddr, awvalid: awValid};
   assign w   = '{wdata: wData, wstrb: '1, wvalid: wValid};
   assign rsp = '{done: rspDone, err: rspErr};

endmodule

/* hdl/axiReadMaster.sv */
`include "dmaRing_cfg.svh"

module axiReadMaster
   import dmaRingPkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  rdReq_t req,
   output rdRsp_t rsp,
   output axiAr_t ar,
   input  logic   arready,
   input  axiR_t  r,
   output logic   rready
);

   typedef enum logic [1:0] {
      stIdle,
      stAddr,
      stData
   } rdState_t;

   rdState_t           state;
   logic               arValid;
   logic [`ADDR_W-1:0] arAddr;
   logic               rspDone;
   logic               rspErr;
   beatWord_t          rspData;
   logic               take;
   logic               rDone;

   // Request still held in its done cycle is not taken twice
   assign take  = (state == stIdle) && req.valid && !rspDone;
   assign rDone = (state == stData) && r.rvalid;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= stIdle;
         arValid <= 1'b0;
         rready  <= 1'b0;
         rspDone <= 1'b0;
         rspErr  <= 1'b0;
      end else begin
         rspDone <= 1'b0;
         case (state)
            stIdle: begin
               if (take) begin
                  arValid <= 1'b1;
                  state   <= stAddr;
               end
            end
            stAddr: begin
               if (arready) begin
                  arValid <= 1'b0;
                  rready  <= 1'b1;
                  state   <= stData;
               end
            end
            stData: begin
               if (r.rvalid) begin
                  rready  <= 1'b0;
                  rspDone <= 1'b1;
                  rspErr  <= (r.rresp != 2'b00);
                  state   <= stIdle;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         arAddr <= req.addr;
      end
      if (rDone) begin
         rspData.data <= r.rdata;
      end
   end

   assign ar  = '{araddr: arAddr, arvalid: arValid};
   assign rsp = '{done: rspDone, err: rspErr, data: rspData};

endmodule

/* hdl/dmaRingPkg.sv */
`include "dmaRing_cfg.svh"

package dmaRingPkg;

   typedef logic [$clog2(`RING_SLOTS)-1:0]  slotIdx_t;
   typedef logic [$clog2(`BLOCK_BEATS)-1:0] beatIdx_t;

   // Host pointer layout, slot index in bits 15:12
   typedef struct packed {
      logic [`DATA_W-17:0] rsvd;
      logic [3:0]          slot;
      logic [11:0]         zero;
   } ptrWord_t;

   typedef union packed {
      ptrWord_t            ptr;
      logic [`DATA_W-1:0]  data;
   } beatWord_t;

   typedef struct packed {
      logic               valid;
      logic [`ADDR_W-1:0] addr;
   } rdReq_t;

   typedef struct packed {
      logic      done;
      logic      err;
      beatWord_t data;
   } rdRsp_t;

   typedef struct packed {
      logic               valid;
      logic [`ADDR_W-1:0] addr;
      beatWord_t          data;
   } wrReq_t;

   typedef struct packed {
      logic done;
      logic err;
   } wrRsp_t;

   typedef struct packed {
      logic [`ADDR_W-1:0] araddr;
      logic               arvalid;
   } axiAr_t;

   typedef struct packed {
      logic [`DATA_W-1:0] rdata;
      logic [1:0]         rresp;
      logic               rvalid;
   } axiR_t;

   typedef struct packed {
      logic [`ADDR_W-1:0] awaddr;
      logic               awvalid;
   } axiAw_t;

   typedef struct packed {
      logic [`DATA_W-1:0]   wdata;
      logic [`DATA_W/8-1:0] wstrb;
      logic                 wvalid;
   } axiW_t;

   typedef struct packed {
      logic [1:0] bresp;
      logic       bvalid;
   } axiB_t;

endpackage

/* hdl/dmaRing_cfg.svh */
`ifndef DMA_RING_CFG_SVH
`define DMA_RING_CFG_SVH

`define ADDR_W        64
`define DATA_W        128
`define BLOCK_BEATS   4
`define BEAT_STRIDE   64'h10
`define RING_SLOTS    8
`define SLOT_STRIDE   64'h1000
`define IB_RING_BASE  64'h1000
`define OB_RING_BASE  64'h8000
`define PTR_IN_ADDR   64'h10
`define PTR_OUT_ADDR  64'h30
`define POLL_INTERVAL 32

`endif
